//--- design/desc_pkg.sv
// Descriptor types for the host-to-card queue, regular and stored formats
// Counter, pointer and index words, status flags and format conversions
`default_nettype none

package desc_pkg;

   // Wrap bit position in the pointer status words
   localparam int PTR_WRAP_BIT = 15;

   typedef logic [31:0] cnt_t;
   typedef logic [15:0] ptr_reg_t;
   typedef logic [PTR_WRAP_BIT-1:0] ring_idx_t;
   typedef logic [63:0] dma_addr_t;
   typedef logic [31:0] dma_len_t;
   typedef logic [7:0] user_t;

   // Regular descriptor as seen by the host
   typedef struct packed {
      logic [21:0] reserved;
      user_t       user;
      logic        spb;
      logic        eop;
      dma_addr_t   src_addr;
      dma_len_t    len;
   } host_desc_t;

   // Stored form, reserved bits stripped
   typedef struct packed {
      user_t     user;
      logic      spb;
      logic      eop;
      dma_addr_t src_addr;
      dma_len_t  len;
   } sav_desc_t;

   typedef struct packed {
      logic oflow;
      logic uflow;
      logic full;
      logic empty;
   } desc_status_t;

   function automatic sav_desc_t to_sav(input host_desc_t d);
      sav_desc_t s;
      s.user     = d.user;
      s.spb      = d.spb;
      s.eop      = d.eop;
      s.src_addr = d.src_addr;
      s.len      = d.len;
      return s;
   endfunction

   function automatic host_desc_t from_sav(input sav_desc_t s);
      host_desc_t d;
      d.reserved = '0;
      d.user     = s.user;
      d.spb      = s.spb;
      d.eop      = s.eop;
      d.src_addr = s.src_addr;
      d.len      = s.len;
      return d;
   endfunction

endpackage

`default_nettype wire

//--- design/desc_ram.sv
// Descriptor ring storage
// One write port, one read port with registered output
`default_nettype none

module desc_ram #(
   parameter int DESC_DEPTH = 64,
   localparam int IDX_W = $clog2(DESC_DEPTH)
) (
   input  logic                clk,
   input  logic                wr_en,
   input  logic [IDX_W-1:0]    wr_addr,
   input  desc_pkg::sav_desc_t wr_data,
   input  logic                rd_en,
   input  logic [IDX_W-1:0]    rd_addr,
   output desc_pkg::sav_desc_t rd_data
);
   import desc_pkg::*;

   sav_desc_t mem [DESC_DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Output holds between reads
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

//--- design/desc_ring_ctrl.sv
// Host write pipeline and ring pointers with full, empty and overflow flags
// RAM port arbitration between host, CSR and prefetch
`default_nettype none

module desc_ring_ctrl #(
   parameter int DESC_DEPTH = 64,
   localparam int IDX_W = $clog2(DESC_DEPTH)
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 host_wr,
   input  desc_pkg::host_desc_t host_desc,
   output logic                 host_wr_q,
   input  logic                 csr_wr_pend,
   input  logic                 csr_rd_pend,
   input  desc_pkg::ring_idx_t  csr_addr,
   input  desc_pkg::sav_desc_t  csr_wdata,
   output logic                 csr_wr_grant,
   output logic                 csr_rd_grant,
   input  logic                 ram_pop,
   output logic                 ram_empty,
   output logic                 full,
   output logic                 oflow,
   output desc_pkg::ptr_reg_t   wr_ptr,
   output desc_pkg::ptr_reg_t   rd_ptr,
   output logic                 ram_wr_en,
   output logic [IDX_W-1:0]     ram_wr_addr,
   output desc_pkg::sav_desc_t  ram_wr_data,
   output logic                 ram_rd_en,
   output logic [IDX_W-1:0]     ram_rd_addr
);
   import desc_pkg::*;

   typedef logic [IDX_W-1:0] idx_t;
   // Wrap bit on top of the index
   typedef logic [IDX_W:0] ptr_t;

   logic      host_wr_d;
   sav_desc_t host_desc_d;
   ptr_t      wr_q;
   ptr_t      rd_q;
   ptr_t      wr_nxt;
   ptr_t      rd_nxt;
   idx_t      csr_idx;

   function automatic ptr_t ptr_inc(input ptr_t p);
      ptr_t q;
      q = p;
      if (p[IDX_W-1:0] == idx_t'(DESC_DEPTH - 1)) begin
         q[IDX_W-1:0] = '0;
         q[IDX_W]     = ~p[IDX_W];
      end else begin
         q[IDX_W-1:0] = p[IDX_W-1:0] + 1'b1;
      end
      return q;
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         host_wr_d <= 1'b0;
      end else begin
         host_wr_d <= host_wr;
      end
   end

   always_ff @(posedge clk) begin
      if (host_wr) begin
         host_desc_d <= to_sav(host_desc);
      end
   end

   // A write that finds the ring full is dropped
   assign host_wr_q = host_wr_d & ~full;
   assign wr_nxt    = ptr_inc(wr_q);
   assign rd_nxt    = ptr_inc(rd_q);
   assign csr_idx   = csr_addr[IDX_W-1:0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_q      <= '0;
         rd_q      <= '0;
         full      <= 1'b0;
         ram_empty <= 1'b1;
         oflow     <= 1'b0;
      end else begin
         if (host_wr_q) begin
            wr_q <= wr_nxt;
         end
         if (ram_pop) begin
            rd_q <= rd_nxt;
         end
         if (host_wr_q && !ram_pop) begin
            full      <= (wr_nxt[IDX_W] != rd_q[IDX_W]) &&
                         (wr_nxt[IDX_W-1:0] == rd_q[IDX_W-1:0]);
            ram_empty <= 1'b0;
         end else if (ram_pop && !host_wr_q) begin
            full      <= 1'b0;
            ram_empty <= (rd_nxt == wr_q);
         end
         oflow <= host_wr_d & full;
      end
   end

   // Host owns the write port, prefetch owns the read port
   assign csr_wr_grant = csr_wr_pend & ~host_wr_d;
   assign ram_wr_en    = host_wr_q | csr_wr_grant;
   assign ram_wr_addr  = host_wr_q ? wr_q[IDX_W-1:0] : csr_idx;
   assign ram_wr_data  = host_wr_q ? host_desc_d : csr_wdata;

   assign csr_rd_grant = csr_rd_pend & ~ram_pop;
   assign ram_rd_en    = ram_pop | csr_rd_grant;
   assign ram_rd_addr  = ram_pop ? rd_q[IDX_W-1:0] : csr_idx;

   always_comb begin
      wr_ptr               = '0;
      wr_ptr[IDX_W-1:0]    = wr_q[IDX_W-1:0];
      wr_ptr[PTR_WRAP_BIT] = wr_q[IDX_W];
      rd_ptr               = '0;
      rd_ptr[IDX_W-1:0]    = rd_q[IDX_W-1:0];
      rd_ptr[PTR_WRAP_BIT] = rd_q[IDX_W];
   end

   // Flags agree with the pointer distance, so full and empty never meet
   a_flags_match_ptrs: assert property (@(posedge clk) disable iff (!rst_n)
      (ram_empty == (wr_q == rd_q)) &&
      (full == ((wr_q[IDX_W] != rd_q[IDX_W]) &&
                (wr_q[IDX_W-1:0] == rd_q[IDX_W-1:0]))))
      else $error("ring flags disagree with the pointers");

endmodule

`default_nettype wire

//--- design/desc_csr_port.sv
// CSR access to the descriptor RAM
// Request latching, acknowledge and read data conversion
`default_nettype none

module desc_csr_port (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 csr_wr,
   input  logic                 csr_rd,
   input  desc_pkg::ring_idx_t  csr_addr,
   input  desc_pkg::host_desc_t csr_wdata,
   output logic                 csr_wr_pend,
   output logic                 csr_rd_pend,
   output desc_pkg::ring_idx_t  csr_addr_q,
   output desc_pkg::sav_desc_t  csr_wdata_q,
   input  logic                 csr_wr_grant,
   input  logic                 csr_rd_grant,
   input  desc_pkg::sav_desc_t  ram_rdata,
   output logic                 csr_ack,
   output desc_pkg::host_desc_t csr_rdata
);
   import desc_pkg::*;

   // RAM data is valid the cycle after a read grant
   logic rd_grant_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_wr_pend <= 1'b0;
         csr_rd_pend <= 1'b0;
         rd_grant_q  <= 1'b0;
         csr_ack     <= 1'b0;
      end else begin
         if (csr_wr) begin
            csr_wr_pend <= 1'b1;
         end else if (csr_wr_grant) begin
            csr_wr_pend <= 1'b0;
         end
         if (csr_rd) begin
            csr_rd_pend <= 1'b1;
         end else if (csr_rd_grant) begin
            csr_rd_pend <= 1'b0;
         end
         rd_grant_q <= csr_rd_grant;
         csr_ack    <= csr_wr_grant | rd_grant_q;
      end
   end

   // Arguments held until the grant
   always_ff @(posedge clk) begin
      if (csr_wr || csr_rd) begin
         csr_addr_q <= csr_addr;
      end
      if (csr_wr) begin
         csr_wdata_q <= to_sav(csr_wdata);
      end
   end

   always_ff @(posedge clk) begin
      if (rd_grant_q) begin
         csr_rdata <= from_sav(ram_rdata);
      end
   end

   a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
      csr_ack |-> $past(csr_wr_pend) || $past(csr_rd_pend, 2))
      else $error("csr_ack without a pending request");

endmodule

`default_nettype wire

//--- design/desc_prefetch.sv
// Flow-through prefetch towards the data mover
// Two-entry buffer filled ahead from the RAM, underflow flag
`default_nettype none

module desc_prefetch (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 ram_empty,
   input  desc_pkg::sav_desc_t  ram_rdata,
   output logic                 ram_pop,
   input  logic                 dm_pop,
   output logic                 dm_valid,
   output desc_pkg::host_desc_t dm_desc,
   output logic                 uflow
);
   import desc_pkg::*;

   sav_desc_t  slot_q [2];
   logic [1:0] cnt;
   logic [1:0] occ;
   logic       inflight;
   logic       wr_sel;
   logic       rd_sel;
   logic       take;

   assign dm_valid = (cnt != 2'd0);
   assign dm_desc  = from_sav(slot_q[rd_sel]);
   assign take     = dm_pop & dm_valid;

   // Buffered entries plus the read still on its way from the RAM
   assign occ     = cnt + {1'b0, inflight};
   assign ram_pop = ~ram_empty & ((occ < 2'd2) | take);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt      <= 2'd0;
         inflight <= 1'b0;
         wr_sel   <= 1'b0;
         rd_sel   <= 1'b0;
         uflow    <= 1'b0;
      end else begin
         inflight <= ram_pop;
         cnt      <= cnt + {1'b0, inflight} - {1'b0, take};
         if (inflight) begin
            wr_sel <= ~wr_sel;
         end
         if (take) begin
            rd_sel <= ~rd_sel;
         end
         uflow <= dm_pop & ~dm_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (inflight) begin
         slot_q[wr_sel] <= ram_rdata;
      end
   end

   a_hold_until_pop: assert property (@(posedge clk) disable iff (!rst_n)
      dm_valid && !dm_pop |=> dm_valid && $stable(dm_desc))
      else $error("dm_desc dropped or changed without a pop");

endmodule

`default_nettype wire

//--- design/desc_credit.sv
// Credit consumed and limit counters, completed descriptor counter
// Write-back request pulses
`default_nettype none

module desc_credit #(
   parameter int DESC_DEPTH = 64
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           host_wr_q,
   input  logic           dm_pop,
   input  logic           dm_cnt_inc,
   input  logic           clr_cdt_consumed,
   input  logic           clr_cdt_limit,
   input  logic           clr_desc_cnt,
   output desc_pkg::cnt_t cdt_consumed,
   output desc_pkg::cnt_t cdt_limit,
   output desc_pkg::cnt_t desc_cnt,
   output logic           wb_limit_req,
   output desc_pkg::cnt_t wb_limit,
   output logic           wb_cnt_req,
   output desc_pkg::cnt_t wb_cnt
);
   import desc_pkg::*;

   localparam cnt_t LIMIT_INIT = cnt_t'(DESC_DEPTH);

   // Clear wins over increment
   function automatic cnt_t cnt_next(input logic clr, input logic inc,
                                     input cnt_t cur, input cnt_t init);
      if (clr) begin
         return init;
      end
      return inc ? cur + cnt_t'(1) : cur;
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cdt_consumed <= '0;
         cdt_limit    <= LIMIT_INIT;
         desc_cnt     <= '0;
         wb_limit_req <= 1'b0;
         wb_cnt_req   <= 1'b0;
      end else begin
         cdt_consumed <= cnt_next(clr_cdt_consumed, host_wr_q, cdt_consumed, '0);
         cdt_limit    <= cnt_next(clr_cdt_limit, dm_pop, cdt_limit, LIMIT_INIT);
         desc_cnt     <= cnt_next(clr_desc_cnt, dm_cnt_inc, desc_cnt, '0);
         wb_limit_req <= dm_pop;
         wb_cnt_req   <= dm_cnt_inc;
      end
   end

   // Counters already hold the new value when the request fires
   assign wb_limit = cdt_limit;
   assign wb_cnt   = desc_cnt;

endmodule

`default_nettype wire

//--- design/desc_queue.sv
// Host-to-card descriptor queue top level
// Wires CSR port, ring control, RAM, prefetch and credit blocks
`default_nettype none

module desc_queue #(
   parameter int DESC_DEPTH = 64,
   localparam int IDX_W = $clog2(DESC_DEPTH)
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   host_wr,
   input  desc_pkg::host_desc_t   host_desc,
   input  logic                   csr_wr,
   input  logic                   csr_rd,
   input  logic [IDX_W-1:0]       csr_addr,
   input  desc_pkg::host_desc_t   csr_wdata,
   output logic                   csr_ack,
   output desc_pkg::host_desc_t   csr_rdata,
   input  logic                   dm_pop,
   output logic                   dm_valid,
   output desc_pkg::host_desc_t   dm_desc,
   input  logic                   dm_cnt_inc,
   output logic                   wb_limit_req,
   output desc_pkg::cnt_t         wb_limit,
   output logic                   wb_cnt_req,
   output desc_pkg::cnt_t         wb_cnt,
   input  logic                   clr_cdt_consumed,
   input  logic                   clr_cdt_limit,
   input  logic                   clr_desc_cnt,
   output desc_pkg::desc_status_t status,
   output desc_pkg::ptr_reg_t     wr_ptr,
   output desc_pkg::ptr_reg_t     rd_ptr,
   output desc_pkg::cnt_t         cdt_consumed,
   output desc_pkg::cnt_t         cdt_limit,
   output desc_pkg::cnt_t         desc_cnt
);
   import desc_pkg::*;

   logic             csr_wr_pend;
   logic             csr_rd_pend;
   ring_idx_t        csr_addr_q;
   sav_desc_t        csr_wdata_q;
   logic             csr_wr_grant;
   logic             csr_rd_grant;
   logic             host_wr_q;
   logic             ram_pop;
   logic             ram_empty;
   logic             full;
   logic             oflow;
   logic             uflow;
   logic             ram_wr_en;
   logic [IDX_W-1:0] ram_wr_addr;
   sav_desc_t        ram_wr_data;
   logic             ram_rd_en;
   logic [IDX_W-1:0] ram_rd_addr;
   sav_desc_t        ram_rdata;

   desc_csr_port i_csr_port (
      .clk          (clk),
      .rst_n        (rst_n),
      .csr_wr       (csr_wr),
      .csr_rd       (csr_rd),
      .csr_addr     (ring_idx_t'(csr_addr)),
      .csr_wdata    (csr_wdata),
      .csr_wr_pend  (csr_wr_pend),
      .csr_rd_pend  (csr_rd_pend),
      .csr_addr_q   (csr_addr_q),
      .csr_wdata_q  (csr_wdata_q),
      .csr_wr_grant (csr_wr_grant),
      .csr_rd_grant (csr_rd_grant),
      .ram_rdata    (ram_rdata),
      .csr_ack      (csr_ack),
      .csr_rdata    (csr_rdata)
   );

   desc_ring_ctrl #(.DESC_DEPTH(DESC_DEPTH)) i_ring_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .host_wr      (host_wr),
      .host_desc    (host_desc),
      .host_wr_q    (host_wr_q),
      .csr_wr_pend  (csr_wr_pend),
      .csr_rd_pend  (csr_rd_pend),
      .csr_addr     (csr_addr_q),
      .csr_wdata    (csr_wdata_q),
      .csr_wr_grant (csr_wr_grant),
      .csr_rd_grant (csr_rd_grant),
      .ram_pop      (ram_pop),
      .ram_empty    (ram_empty),
      .full         (full),
      .oflow        (oflow),
      .wr_ptr       (wr_ptr),
      .rd_ptr       (rd_ptr),
      .ram_wr_en    (ram_wr_en),
      .ram_wr_addr  (ram_wr_addr),
      .ram_wr_data  (ram_wr_data),
      .ram_rd_en    (ram_rd_en),
      .ram_rd_addr  (ram_rd_addr)
   );

   desc_ram #(.DESC_DEPTH(DESC_DEPTH)) i_ram (
      .clk     (clk),
      .wr_en   (ram_wr_en),
      .wr_addr (ram_wr_addr),
      .wr_data (ram_wr_data),
      .rd_en   (ram_rd_en),
      .rd_addr (ram_rd_addr),
      .rd_data (ram_rdata)
   );

   desc_prefetch i_prefetch (
      .clk       (clk),
      .rst_n     (rst_n),
      .ram_empty (ram_empty),
      .ram_rdata (ram_rdata),
      .ram_pop   (ram_pop),
      .dm_pop    (dm_pop),
      .dm_valid  (dm_valid),
      .dm_desc   (dm_desc),
      .uflow     (uflow)
   );

   desc_credit #(.DESC_DEPTH(DESC_DEPTH)) i_credit (
      .clk              (clk),
      .rst_n            (rst_n),
      .host_wr_q        (host_wr_q),
      .dm_pop           (dm_pop),
      .dm_cnt_inc       (dm_cnt_inc),
      .clr_cdt_consumed (clr_cdt_consumed),
      .clr_cdt_limit    (clr_cdt_limit),
      .clr_desc_cnt     (clr_desc_cnt),
      .cdt_consumed     (cdt_consumed),
      .cdt_limit        (cdt_limit),
      .desc_cnt         (desc_cnt),
      .wb_limit_req     (wb_limit_req),
      .wb_limit         (wb_limit),
      .wb_cnt_req       (wb_cnt_req),
      .wb_cnt           (wb_cnt)
   );

   // Empty as seen by the data mover, not the RAM
   assign status = '{oflow: oflow, uflow: uflow, full: full, empty: ~dm_valid};

endmodule

`default_nettype wire

//--- testbench/tb_desc_queue.sv
// Pattern-driven testbench for the descriptor queue
// Queue model, counter model, output monitor and check task
`default_nettype none

module tb_desc_queue;
   timeunit 1ns;
   timeprecision 1ps;
   import desc_pkg::*;

   localparam int DEPTH = 16;
   // Ring slots plus the two prefetch slots
   localparam int CAPACITY = DEPTH + 2;
   localparam int TIMEOUT = 50;

   logic         clk;
   logic         rst_n;
   logic         host_wr;
   host_desc_t   host_desc;
   logic         csr_wr;
   logic         csr_rd;
   logic [3:0]   csr_addr;
   host_desc_t   csr_wdata;
   logic         csr_ack;
   host_desc_t   csr_rdata;
   logic         dm_pop;
   logic         dm_valid;
   host_desc_t   dm_desc;
   logic         dm_cnt_inc;
   logic         wb_limit_req;
   cnt_t         wb_limit;
   logic         wb_cnt_req;
   cnt_t         wb_cnt;
   logic         clr_cdt_consumed;
   logic         clr_cdt_limit;
   logic         clr_desc_cnt;
   desc_status_t status;
   ptr_reg_t     wr_ptr;
   ptr_reg_t     rd_ptr;
   cnt_t         cdt_consumed;
   cnt_t         cdt_limit;
   cnt_t         desc_cnt;

   int           errors = 0;
   int           timeouts = 0;
   int           oflow_seen = 0;
   int           uflow_seen = 0;
   int           ack_seen = 0;
   int           wb_cnt_seen = 0;
   int           csr_reqs = 0;
   int           cnt_pulses = 0;
   int           gen_idx = 0;
   int           acc_cnt = 0;
   int           race_slot = 0;
   logic [127:0] model_q[$];
   logic [127:0] ram_model[DEPTH];
   logic [31:0]  lim_q[$];
   logic [31:0]  cnt_q[$];
   logic [31:0]  exp_limit = 32'(DEPTH);
   logic [31:0]  exp_cnt = 32'd0;

   desc_queue #(.DESC_DEPTH(DEPTH)) i_dut (.*);

   always #20 clk = ~clk;

   task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Reserved bits never reach the data mover or the CSR read data
   function automatic logic [127:0] strip(input logic [127:0] d);
      logic [127:0] r;
      r = d;
      r[127:106] = '0;
      return r;
   endfunction

   // Status pointer word, index in the low bits and wrap bit on top
   function automatic ptr_reg_t ptr_word(input int count);
      ptr_reg_t p;
      p = '0;
      p[3:0] = 4'(count % DEPTH);
      p[15] = 1'((count / DEPTH) % 2);
      return p;
   endfunction

   function automatic logic [127:0] gen_desc(input int i);
      return {22'h3f0f0, 8'(i), 1'(i), 1'b1, 64'h0000_2000_0000_0000 + 64'(i * 64),
              32'(i + 256)};
   endfunction

   task automatic idle_gap();
      repeat ($urandom_range(3)) @(posedge clk);
   endtask

   task automatic wait_for(input string what, output bit ok);
      int n;
      n = 0;
      ok = 1'b0;
      while (n < TIMEOUT && !ok) begin
         @(posedge clk);
         n++;
         ok = (what == "dm_valid") ? dm_valid : csr_ack;
      end
      if (!ok) begin
         timeouts++;
         $display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
      end
   endtask

   task automatic host_write(input logic [127:0] d, input bit race_csr);
      bit ok;
      bit race;
      int prev;
      // Rewrite the last stored slot through the CSR port in the same cycle
      race = race_csr && (acc_cnt > 0);
      prev = (acc_cnt + DEPTH - 1) % DEPTH;
      @(posedge clk);
      host_wr   <= 1'b1;
      host_desc <= d;
      if (race) begin
         csr_addr  <= 4'(prev);
         csr_wdata <= ram_model[prev];
         csr_wr    <= 1'b1;
         csr_reqs++;
      end
      @(posedge clk);
      host_wr <= 1'b0;
      csr_wr  <= 1'b0;
      if (model_q.size() < CAPACITY) begin
         model_q.push_back(strip(d));
         ram_model[acc_cnt % DEPTH] = strip(d);
         acc_cnt++;
      end
      if (race) begin
         wait_for("csr_ack", ok);
      end
   endtask

   task automatic pop_check(input logic [127:0] exp, input bit use_file, output bit ok);
      bit         ack_ok;
      logic [3:0] slot;
      wait_for("dm_valid", ok);
      if (ok) begin
         if (use_file) begin
            check("dm_desc", dm_desc, exp);
         end
         if (model_q.size() == 0) begin
            errors++;
            $display("Data mover offered a descriptor the model does not hold");
         end else begin
            check("dm_desc (model)", dm_desc, model_q.pop_front());
         end
         // CSR read lands on the read port in the pop cycle
         slot = 4'(race_slot);
         if (!use_file) begin
            race_slot++;
            csr_addr <= slot;
            csr_rd   <= 1'b1;
            csr_reqs++;
            @(posedge clk);
            csr_rd <= 1'b0;
         end
         dm_pop <= 1'b1;
         exp_limit++;
         lim_q.push_back(exp_limit);
         @(posedge clk);
         dm_pop <= 1'b0;
         if (!use_file) begin
            wait_for("csr_ack", ack_ok);
            if (ack_ok) check("csr_rdata (race)", csr_rdata, ram_model[slot]);
         end
      end
   endtask

   // Output monitor for pulses and write-back values
   always @(posedge clk) begin
      if (rst_n) begin
         if (status.oflow) oflow_seen++;
         if (status.uflow) uflow_seen++;
         if (csr_ack) ack_seen++;
         if (wb_limit_req) begin
            if (lim_q.size() == 0) begin
               errors++;
               $display("wb_limit_req at %0t without a pop", $time);
            end else begin
               check("wb_limit", 128'(wb_limit), 128'(lim_q.pop_front()));
            end
         end
         if (wb_cnt_req) begin
            wb_cnt_seen++;
            if (cnt_q.size() == 0) begin
               errors++;
               $display("wb_cnt_req at %0t without a completion pulse", $time);
            end else begin
               check("wb_cnt", 128'(wb_cnt), 128'(cnt_q.pop_front()));
            end
         end
      end
   end

   initial begin
      int           fd;
      int           n;
      int           in_ring;
      string        line;
      byte          op;
      bit           ok;
      bit           aborted;
      logic [127:0] d;
      logic [127:0] e;
      logic [31:0]  a;
      logic [31:0]  k[7];
      clk = 1'b0;
      rst_n = 1'b0;
      host_wr = 1'b0;
      host_desc = '0;
      csr_wr = 1'b0;
      csr_rd = 1'b0;
      csr_addr = '0;
      csr_wdata = '0;
      dm_pop = 1'b0;
      dm_cnt_inc = 1'b0;
      clr_cdt_consumed = 1'b0;
      clr_cdt_limit = 1'b0;
      clr_desc_cnt = 1'b0;
      aborted = 1'b0;
      void'($urandom(32'hb252));
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      fd = $fopen("testbench/desc_patterns.txt", "r");
      if (fd == 0) begin
         errors++;
         aborted = 1'b1;
         $display("Could not open the pattern file");
      end
      while (!aborted && !$feof(fd)) begin
         if ($fgets(line, fd) == 0) break;
         if (line.len() < 2 || line[0] == "#") continue;
         op = line[0];
         idle_gap();
         case (op)
            "H": begin
               void'($sscanf(line, "%c %h", op, d));
               host_write(d, 1'b0);
            end
            "N": begin
               void'($sscanf(line, "%c %d", op, n));
               repeat (n) begin
                  host_write(gen_desc(gen_idx), 1'b1);
                  gen_idx++;
                  idle_gap();
               end
            end
            "P": begin
               void'($sscanf(line, "%c %h", op, e));
               pop_check(e, 1'b1, ok);
               aborted = !ok;
            end
            "M": begin
               void'($sscanf(line, "%c %d", op, n));
               repeat (n) begin
                  if (!aborted) begin
                     pop_check('0, 1'b0, ok);
                     aborted = !ok;
                  end
               end
            end
            "U": begin
               check("status.empty", 128'(status.empty), 128'(1));
               dm_pop <= 1'b1;
               exp_limit++;
               lim_q.push_back(exp_limit);
               @(posedge clk);
               dm_pop <= 1'b0;
            end
            "W", "R": begin
               void'($sscanf(line, "%c %h %h", op, a, d));
               csr_addr <= a[3:0];
               csr_wdata <= d;
               csr_wr <= (op == "W");
               csr_rd <= (op == "R");
               csr_reqs++;
               if (op == "W") ram_model[a[3:0]] = strip(d);
               @(posedge clk);
               csr_wr <= 1'b0;
               csr_rd <= 1'b0;
               wait_for("csr_ack", ok);
               aborted = !ok;
               if (ok && op == "R") check("csr_rdata", csr_rdata, d);
            end
            "C": begin
               dm_cnt_inc <= 1'b1;
               exp_cnt++;
               cnt_q.push_back(exp_cnt);
               cnt_pulses++;
               @(posedge clk);
               dm_cnt_inc <= 1'b0;
            end
            "X": begin
               void'($sscanf(line, "%c %h", op, a));
               clr_cdt_consumed <= a[0];
               clr_cdt_limit <= a[1];
               clr_desc_cnt <= a[2];
               if (a[1]) exp_limit = 32'(DEPTH);
               if (a[2]) exp_cnt = 32'd0;
               @(posedge clk);
               clr_cdt_consumed <= 1'b0;
               clr_cdt_limit <= 1'b0;
               clr_desc_cnt <= 1'b0;
            end
            "K": begin
               void'($sscanf(line, "%c %h %h %h %h %h %h %h", op,
                             k[0], k[1], k[2], k[3], k[4], k[5], k[6]));
               // Let the write pipeline and the flags settle
               repeat (4) @(posedge clk);
               // Prefetch holds up to two entries outside the ring
               in_ring = (model_q.size() > 2) ? model_q.size() - 2 : 0;
               check("cdt_consumed", 128'(cdt_consumed), 128'(k[0]));
               check("cdt_limit", 128'(cdt_limit), 128'(k[1]));
               check("desc_cnt", 128'(desc_cnt), 128'(k[2]));
               check("wr_ptr", 128'(wr_ptr), 128'(k[3]));
               check("rd_ptr", 128'(rd_ptr), 128'(ptr_word(acc_cnt - in_ring)));
               check("status.full", 128'(status.full), 128'(k[4]));
               check("oflow pulses", 128'(oflow_seen), 128'(k[5]));
               check("uflow pulses", 128'(uflow_seen), 128'(k[6]));
            end
            default: begin
               errors++;
               $display("Unknown opcode in the pattern file: %s", line);
            end
         endcase
      end
      if (fd != 0) $fclose(fd);
      repeat (4) @(posedge clk);
      check("csr_ack pulses", 128'(ack_seen), 128'(csr_reqs));
      check("wb_cnt_req pulses", 128'(wb_cnt_seen), 128'(cnt_pulses));
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/desc_patterns.txt
# H desc | P expected | W/R addr desc | U pop on empty | C completion | X clear mask
# N count host writes, M count model pops | K consumed limit cnt wr_ptr full oflow uflow
K 0 10 0 0000 0 0 0
U
K 0 11 0 0000 0 0 1
H fffff7a5000000001000004000000100
H abcde00100000000deadbe0000000080
H 0000030f123456789abcdef000001000
P 000003a5000000001000004000000100
P 0000000100000000deadbe0000000080
P 0000030f123456789abcdef000001000
K 3 14 0 0003 0 0 1
W 9 ffffffffcafef00d0000000000000040
R 9 000003ffcafef00d0000000000000040
C
C
K 3 14 2 0003 0 0 1
X 7
K 0 10 0 0003 0 0 1
N 13
K d 10 0 8000 0 0 1
N 6
K 12 10 0 8005 1 1 1
M 18
K 12 22 0 8005 0 1 1
X 1
X 2
C
K 0 10 1 8005 0 1 1
X 4
K 0 10 0 8005 0 1 1

//--- tb.f
design/desc_pkg.sv
design/desc_ram.sv
design/desc_ring_ctrl.sv
design/desc_csr_port.sv
design/desc_prefetch.sv
design/desc_credit.sv
design/desc_queue.sv
testbench/tb_desc_queue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the descriptor queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --assert -f tb.f --top-module tb_desc_queue \
   && ./obj_dir/Vtb_desc_queue)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1
